// File: Bender.yml
package:
  name: adc_rx_core

sources:
  - common/adc_rx_pkg.sv
  - src/adc_sample_delay.sv
  - trigger/adc_trigger_decode.sv
  - record/adc_record_ctrl.sv
  - src/adc_word_pack.sv
  - src/adc_credit_tx.sv
  - src/adc_rx_core.sv
  - target: test
    files:
      - bench/adc_rx_tb.sv

// File: adc_rx_core.f
common/adc_rx_pkg.sv
src/adc_sample_delay.sv
trigger/adc_trigger_decode.sv
record/adc_record_ctrl.sv
src/adc_word_pack.sv
src/adc_credit_tx.sv
src/adc_rx_core.sv
bench/adc_rx_tb.sv

// File: bench/adc_rx_tb.sv
/*
 * ADC receiver core testbench
 * directed records through start, sync, external, threshold, delay and back-pressure
 */
`timescale 1ns/1ps

module adc_rx_tb;
    import adc_rx_pkg::*;

    localparam logic [1:0] ADC_ID      = 2'd2;
    localparam logic [0:0] HEADER_ID   = 1'b1;
    localparam int         FIFO_DEPTH  = 8;
    localparam int         CREDITS     = 4;
    localparam int         TIMEOUT_CYC = 4000; // six records of under 100 cycles each, wide margin
    localparam sample_t    THRESH      = 14'h0040;
    localparam sample_t    LOW_VAL     = 14'h0010;

    logic      ADC_ENC = 1'b0;
    logic      rst_adc_sync;
    sample_t   adc_in;
    logic      adc_sync;
    logic      ext_trigger;
    logic      start;
    logic      cfg_start_with_sync;
    logic      cfg_en_ext_trigger;
    logic      cfg_single_data;
    thr_mode_t cfg_thr_mode;
    sample_t   cfg_threshold;
    rec_cnt_t  cfg_data_cnt;
    logic [7:0] cfg_sample_dly;
    logic      credit_return;
    word_t     word_data;
    logic      word_valid;
    logic      done;
    lost_cnt_t lost_count;

    sample_t ramp = 14'h1000;  // kept far from the threshold and from wrap
    logic    noise_on = 1'b0;
    logic    force_low = 1'b0;
    integer  seed = 64;
    integer  noise;
    logic    paused = 1'b0;
    logic    word_seen = 1'b0;
    logic    ret_dly = 1'b0;
    int      owed = 0;
    word_t   got_q[$];
    int      cycle_cnt = 0;
    int      test_errs = 0;
    int      err_total = 0;
    int      tests_run = 0;
    int      tests_bad = 0;

    adc_rx_core #(
        .ADC_ID     (ADC_ID),
        .HEADER_ID  (HEADER_ID),
        .FIFO_DEPTH (FIFO_DEPTH),
        .CREDITS    (CREDITS)
    ) dut_i (
        .ADC_ENC             (ADC_ENC),
        .rst_adc_sync        (rst_adc_sync),
        .adc_in              (adc_in),
        .adc_sync            (adc_sync),
        .ext_trigger         (ext_trigger),
        .start               (start),
        .cfg_start_with_sync (cfg_start_with_sync),
        .cfg_en_ext_trigger  (cfg_en_ext_trigger),
        .cfg_single_data     (cfg_single_data),
        .cfg_thr_mode        (cfg_thr_mode),
        .cfg_threshold       (cfg_threshold),
        .cfg_data_cnt        (cfg_data_cnt),
        .cfg_sample_dly      (cfg_sample_dly),
        .credit_return       (credit_return),
        .word_data           (word_data),
        .word_valid          (word_valid),
        .done                (done),
        .lost_count          (lost_count)
    );

    always #5 ADC_ENC = ~ADC_ENC;

    // ramp source, noise or a forced low value on request
    always @(posedge ADC_ENC) begin
        ramp <= ramp + 1'b1;
        if (force_low) begin
            adc_in <= LOW_VAL;
        end else if (noise_on) begin
            noise = $random(seed);
            adc_in <= ramp + sample_t'(noise & 32'hff);
        end else begin
            adc_in <= ramp;
        end
    end

    // consumer model
    always @(negedge ADC_ENC) begin
        word_seen = word_valid;
        if (word_valid) begin
            got_q.push_back(word_data);
        end
    end

    always @(posedge ADC_ENC) begin
        ret_dly <= word_seen;
        if (ret_dly && !paused) begin
            credit_return <= 1'b1;  // two cycles after the word
        end else if (ret_dly) begin
            credit_return <= 1'b0;
            owed          <= owed + 1;  // held back while paused
        end else if (!paused && owed > 0) begin
            credit_return <= 1'b1;
            owed          <= owed - 1;
        end else begin
            credit_return <= 1'b0;
        end
    end

    always @(posedge ADC_ENC) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("tests failed");
            $finish;
        end
    end

    // expected word from the tag layout
    function automatic word_t make_word(logic flag, sample_t upper, sample_t smp);
        make_word = {HEADER_ID, ADC_ID, flag, upper, smp};
    endfunction

    task automatic mid_cycle();
        @(negedge ADC_ENC);
        #1;
    endtask

    task automatic prepare_test();
        repeat (8) begin
            mid_cycle();
        end
        got_q.delete();
    endtask

    task automatic pulse_start();
        @(posedge ADC_ENC);
        start <= 1'b1;
        @(posedge ADC_ENC);
        start <= 1'b0;
    endtask

    task automatic wait_words(input int n);
        while (got_q.size() < n) begin
            mid_cycle();
        end
        repeat (10) begin
            mid_cycle();  // room for any extra word
        end
    endtask

    task automatic check_count(input int n);
        if (got_q.size() != n) begin
            $display("wrong number of words: got %0d, expected %0d", got_q.size(), n);
            test_errs++;
        end
    endtask

    task automatic check_word(input int idx, input word_t exp);
        if (idx >= got_q.size()) begin
            $display("word %0d never arrived", idx);
            test_errs++;
        end else if (got_q[idx] !== exp) begin
            $display("** Error word_data[%0d]: got %h expected %h", idx, got_q[idx], exp);
            test_errs++;
        end
    endtask

    task automatic check_done();
        if (done !== 1'b1) begin
            $display("** Error done: got %h expected %h", done, 1'b1);
            test_errs++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, test_errs);
            tests_bad++;
        end
        err_total += test_errs;
        tests_run++;
        test_errs = 0;
    endtask

    task automatic test_single();
        sample_t base;
        prepare_test();
        @(posedge ADC_ENC);
        cfg_data_cnt <= 24'd5;
        mid_cycle();
        base = adc_in;
        pulse_start();
        wait_words(5);
        check_count(5);
        for (int k = 0; k < 5; k++) begin
            check_word(k, make_word(k == 0, '0, sample_t'(base + 3 + k)));
        end
        check_done();
        finish_test("test 1 single start");
    endtask

    task automatic test_sync();
        sample_t base;
        prepare_test();
        @(posedge ADC_ENC);
        cfg_start_with_sync <= 1'b1;
        cfg_data_cnt        <= 24'd4;
        pulse_start();
        repeat (18) @(posedge ADC_ENC);
        mid_cycle();
        base = adc_in;
        if (got_q.size() != 0) begin
            $display("words arrived before the adc_sync edge");
            test_errs++;
        end
        @(posedge ADC_ENC);
        adc_sync <= 1'b1;  // 20 cycles after start
        wait_words(4);
        @(posedge ADC_ENC);
        adc_sync            <= 1'b0;
        cfg_start_with_sync <= 1'b0;
        check_count(4);
        for (int k = 0; k < 4; k++) begin
            check_word(k, make_word(k == 0, '0, sample_t'(base + 3 + k)));
        end
        finish_test("test 2 sync start");
    endtask

    task automatic test_ext_double();
        sample_t base;
        prepare_test();
        @(posedge ADC_ENC);
        cfg_en_ext_trigger <= 1'b1;
        cfg_single_data    <= 1'b0;
        cfg_data_cnt       <= 24'd8;
        mid_cycle();
        base = adc_in;
        @(posedge ADC_ENC);
        ext_trigger <= 1'b1;
        @(posedge ADC_ENC);
        ext_trigger <= 1'b0;
        wait_words(4);
        @(posedge ADC_ENC);
        cfg_en_ext_trigger <= 1'b0;
        cfg_single_data    <= 1'b1;
        check_count(4);
        for (int k = 0; k < 4; k++) begin
            check_word(k, make_word(1'b0, sample_t'(base + 3 + 2 * k),
                                    sample_t'(base + 4 + 2 * k)));
        end
        finish_test("test 3 external trigger, paired samples");
    endtask

    task automatic test_threshold();
        prepare_test();
        @(posedge ADC_ENC);
        noise_on      <= 1'b1;
        cfg_data_cnt  <= 24'd4;  // outlasts the repeated hits of the low run
        cfg_threshold <= THRESH;
        @(posedge ADC_ENC);
        cfg_thr_mode <= THR_BELOW;
        repeat (30) @(posedge ADC_ENC);
        mid_cycle();
        if (got_q.size() != 0) begin
            $display("record started on noisy data above the threshold");
            test_errs++;
        end
        @(posedge ADC_ENC);
        force_low <= 1'b1;
        repeat (4) @(posedge ADC_ENC);
        force_low <= 1'b0;
        wait_words(4);
        @(posedge ADC_ENC);
        noise_on     <= 1'b0;
        cfg_thr_mode <= THR_OFF;
        check_count(4);
        check_word(0, make_word(1'b1, '0, LOW_VAL));
        check_word(1, make_word(1'b0, '0, LOW_VAL));
        finish_test("test 4 threshold below");
    endtask

    task automatic test_delay();
        sample_t base;
        prepare_test();
        @(posedge ADC_ENC);
        cfg_sample_dly <= 8'd10;
        cfg_data_cnt   <= 24'd5;
        repeat (20) @(posedge ADC_ENC);  // delay line refills
        mid_cycle();
        base = adc_in;
        pulse_start();
        wait_words(5);
        @(posedge ADC_ENC);
        cfg_sample_dly <= 8'd0;
        check_count(5);
        for (int k = 0; k < 5; k++) begin
            check_word(k, make_word(k == 0, '0, sample_t'(base + 3 - 10 + k)));
        end
        finish_test("test 5 sample delay");
    endtask

    task automatic test_backpressure();
        sample_t   base;
        lost_cnt_t exp_lost;
        exp_lost = lost_cnt_t'(20 - CREDITS - FIFO_DEPTH);
        prepare_test();
        @(posedge ADC_ENC);
        paused       <= 1'b1;
        cfg_data_cnt <= 24'd20;
        mid_cycle();
        base = adc_in;
        pulse_start();
        wait_words(CREDITS);
        repeat (30) begin
            mid_cycle();
        end
        check_count(CREDITS);
        if (lost_count !== exp_lost) begin
            $display("** Error lost_count: got %h expected %h", lost_count, exp_lost);
            test_errs++;
        end
        @(posedge ADC_ENC);
        paused <= 1'b0;
        wait_words(CREDITS + FIFO_DEPTH);
        check_count(CREDITS + FIFO_DEPTH);
        for (int k = 0; k < CREDITS + FIFO_DEPTH; k++) begin
            check_word(k, make_word(k == 0, '0, sample_t'(base + 3 + k)));
        end
        check_done();
        finish_test("test 6 back-pressure");
    endtask

    initial begin
        rst_adc_sync        = 1'b1;
        adc_in              = '0;
        adc_sync            = 1'b0;
        ext_trigger         = 1'b0;
        start               = 1'b0;
        cfg_start_with_sync = 1'b0;
        cfg_en_ext_trigger  = 1'b0;
        cfg_single_data     = 1'b1;
        cfg_thr_mode        = THR_OFF;
        cfg_threshold       = '0;
        cfg_data_cnt        = '0;
        cfg_sample_dly      = '0;
        credit_return       = 1'b0;
        repeat (2) @(posedge ADC_ENC);
        rst_adc_sync <= 1'b0;
        test_single();
        test_sync();
        test_ext_double();
        test_threshold();
        test_delay();
        test_backpressure();
        $display("summary: %0d tests run, %0d with errors, %0d errors total",
                 tests_run, tests_bad, err_total);
        if (err_total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: common/adc_rx_pkg.sv
/*
 * ADC receiver shared definitions
 * sample, output word, record counter and threshold mode types
 */
package adc_rx_pkg;

    localparam int SAMPLE_W = 14;
    localparam int WORD_W   = 32;
    localparam int REC_W    = 24;
    localparam int LOST_W   = 8;

    // one raw ADC conversion, unsigned
    typedef logic [SAMPLE_W-1:0] sample_t;

    // tagged word handed to the consumer
    typedef logic [WORD_W-1:0] word_t;

    // record length and running position
    typedef logic [REC_W-1:0] rec_cnt_t;

    // dropped word count, saturates at all ones
    typedef logic [LOST_W-1:0] lost_cnt_t;

    // threshold trigger condition on the delayed sample
    typedef enum logic [1:0] {
        THR_OFF   = 2'd0,
        THR_BELOW = 2'd1, // sample below threshold
        THR_ABOVE = 2'd2, // sample above threshold
        THR_FALL  = 2'd3  // drop since last sample exceeds threshold
    } thr_mode_t;

endpackage

// File: record/adc_record_ctrl.sv
/*
 * Record execution
 * counts the configured number of samples after a start, or runs forever
 */
`timescale 1ns/1ps

module adc_record_ctrl (
    input  logic                 ADC_ENC,
    input  logic                 rst_adc_sync,
    input  logic                 trig_start,
    input  adc_rx_pkg::rec_cnt_t cfg_data_cnt,
    output logic                 sample_en,
    output logic                 first_sample,
    output logic                 done
);
    import adc_rx_pkg::*;

    localparam rec_cnt_t REC_MAX = {REC_W{1'b1}};

    rec_cnt_t rec_cnt;
    logic     forever_mode;
    logic     last_sample;
    logic     accept;

    assign forever_mode = (cfg_data_cnt == '0);

    // zero means idle, 1..cfg_data_cnt are sample positions
    assign sample_en    = (rec_cnt != '0) && (forever_mode || rec_cnt <= cfg_data_cnt);
    assign first_sample = sample_en && (rec_cnt == rec_cnt_t'(1));
    assign last_sample  = sample_en && !forever_mode && (rec_cnt == cfg_data_cnt);

    // a finite record in progress is not restarted
    assign accept = trig_start && (!sample_en || forever_mode);

    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync) begin
            rec_cnt <= '0;
        end else if (accept) begin
            rec_cnt <= rec_cnt_t'(1);
        end else if (last_sample) begin
            rec_cnt <= '0; // back to idle
        end else if (sample_en && rec_cnt != REC_MAX) begin
            rec_cnt <= rec_cnt + 1'b1; // forever mode parks at max
        end
    end

    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync) begin
            done <= 1'b1;
        end else if (accept) begin
            done <= 1'b0;
        end else if (last_sample) begin
            done <= 1'b1;
        end
    end

endmodule

// File: src/adc_credit_tx.sv
/*
 * Word transmit stage
 * small word buffer drained against consumer credits, counts dropped words
 */
`timescale 1ns/1ps

module adc_credit_tx #(
    parameter int FIFO_DEPTH = 8,
    parameter int CREDITS    = 4
) (
    input  logic                  ADC_ENC,
    input  logic                  rst_adc_sync,
    input  adc_rx_pkg::word_t     pack_data,
    input  logic                  pack_valid,
    input  logic                  credit_return,
    output adc_rx_pkg::word_t     word_data,
    output logic                  word_valid,
    output adc_rx_pkg::lost_cnt_t lost_count
);
    import adc_rx_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int OW = $clog2(FIFO_DEPTH + 1);
    localparam int CW = $clog2(CREDITS + 1);

    word_t         buf_mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [OW-1:0] occupancy;
    logic [CW-1:0] credits;
    logic          full;
    logic          push;
    logic          pop;

    assign full = (occupancy == OW'(FIFO_DEPTH));
    assign push = pack_valid && !full;
    assign pop  = (credits != '0) && (occupancy != '0);

    assign word_valid = pop; // one credit spent per valid cycle
    assign word_data  = buf_mem[rd_ptr];

    always_ff @(posedge ADC_ENC) begin
        if (push) begin
            buf_mem[wr_ptr] <= pack_data;
        end
    end

    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            occupancy <= occupancy + OW'(push) - OW'(pop);
        end
    end

    // spend and return may land in the same cycle
    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync) begin
            credits <= CW'(CREDITS);
        end else begin
            credits <= credits + CW'(credit_return) - CW'(pop);
        end
    end

    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync) begin
            lost_count <= '0;
        end else if (pack_valid && full && lost_count != '1) begin
            lost_count <= lost_count + 1'b1; // saturating
        end
    end

endmodule

// File: src/adc_rx_core.sv
/*
 * ADC receiver acquisition core
 * delay, trigger decode, record, word packing and credit transmit
 */
`timescale 1ns/1ps

module adc_rx_core #(
    parameter logic [1:0] ADC_ID     = 2'd0,
    parameter logic [0:0] HEADER_ID  = 1'b0,
    parameter int         DLY_DEPTH  = 256,
    parameter int         FIFO_DEPTH = 8,
    parameter int         CREDITS    = 4
) (
    input  logic                  ADC_ENC,
    input  logic                  rst_adc_sync,
    input  adc_rx_pkg::sample_t   adc_in,
    input  logic                  adc_sync,
    input  logic                  ext_trigger,
    input  logic                  start,
    input  logic                  cfg_start_with_sync,
    input  logic                  cfg_en_ext_trigger,
    input  logic                  cfg_single_data,
    input  adc_rx_pkg::thr_mode_t cfg_thr_mode,
    input  adc_rx_pkg::sample_t   cfg_threshold,
    input  adc_rx_pkg::rec_cnt_t  cfg_data_cnt,
    input  logic [7:0]            cfg_sample_dly,
    input  logic                  credit_return,
    output adc_rx_pkg::word_t     word_data,
    output logic                  word_valid,
    output logic                  done,
    output adc_rx_pkg::lost_cnt_t lost_count
);
    import adc_rx_pkg::*;

    sample_t dly_sample;
    logic    trig_start;
    logic    sync_rise;
    logic    sample_en;
    logic    first_sample;
    word_t   pack_data;
    logic    pack_valid;

    adc_sample_delay #(
        .DLY_DEPTH (DLY_DEPTH)
    ) u_delay (
        .ADC_ENC        (ADC_ENC),
        .rst_adc_sync   (rst_adc_sync),
        .adc_in         (adc_in),
        .cfg_sample_dly (cfg_sample_dly),
        .dly_sample     (dly_sample)
    );

    adc_trigger_decode u_trigger (
        .ADC_ENC             (ADC_ENC),
        .rst_adc_sync        (rst_adc_sync),
        .start               (start),
        .adc_sync            (adc_sync),
        .ext_trigger         (ext_trigger),
        .cfg_start_with_sync (cfg_start_with_sync),
        .cfg_en_ext_trigger  (cfg_en_ext_trigger),
        .cfg_thr_mode        (cfg_thr_mode),
        .cfg_threshold       (cfg_threshold),
        .dly_sample          (dly_sample),
        .trig_start          (trig_start),
        .sync_rise           (sync_rise)
    );

    adc_record_ctrl u_record (
        .ADC_ENC      (ADC_ENC),
        .rst_adc_sync (rst_adc_sync),
        .trig_start   (trig_start),
        .cfg_data_cnt (cfg_data_cnt),
        .sample_en    (sample_en),
        .first_sample (first_sample),
        .done         (done)
    );

    adc_word_pack #(
        .ADC_ID    (ADC_ID),
        .HEADER_ID (HEADER_ID)
    ) u_pack (
        .ADC_ENC         (ADC_ENC),
        .rst_adc_sync    (rst_adc_sync),
        .dly_sample      (dly_sample),
        .sample_en       (sample_en),
        .first_sample    (first_sample),
        .sync_rise       (sync_rise),
        .cfg_single_data (cfg_single_data),
        .pack_data       (pack_data),
        .pack_valid      (pack_valid)
    );

    adc_credit_tx #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .CREDITS    (CREDITS)
    ) u_tx (
        .ADC_ENC       (ADC_ENC),
        .rst_adc_sync  (rst_adc_sync),
        .pack_data     (pack_data),
        .pack_valid    (pack_valid),
        .credit_return (credit_return),
        .word_data     (word_data),
        .word_valid    (word_valid),
        .lost_count    (lost_count)
    );

endmodule

// File: src/adc_sample_delay.sv
/*
 * ADC sample delay line
 * ring memory giving the sample from a programmable number of cycles back
 */
`timescale 1ns/1ps

module adc_sample_delay #(
    parameter int DLY_DEPTH = 256
) (
    input  logic                ADC_ENC,
    input  logic                rst_adc_sync,
    input  adc_rx_pkg::sample_t adc_in,
    input  logic [7:0]          cfg_sample_dly,
    output adc_rx_pkg::sample_t dly_sample
);
    import adc_rx_pkg::*;

    localparam int AW = $clog2(DLY_DEPTH);

    sample_t       dly_mem [DLY_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW-1:0] dly_w;
    sample_t       rd_q;

    assign dly_w  = AW'(cfg_sample_dly);
    assign rd_ptr = wr_ptr - dly_w + AW'(1); // one slot ahead, read adds a cycle

    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync) begin
            wr_ptr <= '0;
        end else begin
            wr_ptr <= wr_ptr + 1'b1; // free running
        end
    end

    always_ff @(posedge ADC_ENC) begin
        dly_mem[wr_ptr] <= adc_in;
        if (dly_w == AW'(1)) begin
            rd_q <= adc_in; // that slot is written this very cycle
        end else begin
            rd_q <= dly_mem[rd_ptr];
        end
    end

    // zero delay skips the memory
    assign dly_sample = (dly_w == '0) ? adc_in : rd_q;

endmodule

// File: src/adc_word_pack.sv
/*
 * Word result stage
 * packs one or two samples into a tagged 32-bit word
 */
`timescale 1ns/1ps

module adc_word_pack #(
    parameter logic [1:0] ADC_ID    = 2'd0,
    parameter logic [0:0] HEADER_ID = 1'b0
) (
    input  logic                ADC_ENC,
    input  logic                rst_adc_sync,
    input  adc_rx_pkg::sample_t dly_sample,
    input  logic                sample_en,
    input  logic                first_sample,
    input  logic                sync_rise,
    input  logic                cfg_single_data,
    output adc_rx_pkg::word_t   pack_data,
    output logic                pack_valid
);
    import adc_rx_pkg::*;

    sample_t prev_sample;
    logic    prev_rise;
    logic    phase;      // high when a held sample waits for its pair
    logic    pair_done;

    // second sample of a pair, the first of a record never closes one
    assign pair_done = sample_en && !first_sample && phase;

    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync) begin
            phase <= 1'b0;
        end else if (sample_en) begin
            phase <= first_sample ? 1'b1 : ~phase;
        end
    end

    always_ff @(posedge ADC_ENC) begin
        if (sample_en) begin
            prev_sample <= dly_sample;
            prev_rise   <= sync_rise; // edge seen with that sample
        end
    end

    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync) begin
            pack_valid <= 1'b0;
        end else if (cfg_single_data) begin
            pack_valid <= sample_en;
        end else begin
            pack_valid <= pair_done;
        end
    end

    always_ff @(posedge ADC_ENC) begin
        if (sample_en) begin
            if (cfg_single_data) begin
                pack_data <= {HEADER_ID, ADC_ID, first_sample, {SAMPLE_W{1'b0}}, dly_sample};
            end else begin
                pack_data <= {HEADER_ID, ADC_ID, prev_rise, prev_sample, dly_sample};
            end
        end
    end

endmodule

// File: trigger/adc_trigger_decode.sv
/*
 * Record trigger decode
 * merges start, sync edge, external and threshold events into one start pulse
 */
`timescale 1ns/1ps

module adc_trigger_decode (
    input  logic                  ADC_ENC,
    input  logic                  rst_adc_sync,
    input  logic                  start,
    input  logic                  adc_sync,
    input  logic                  ext_trigger,
    input  logic                  cfg_start_with_sync,
    input  logic                  cfg_en_ext_trigger,
    input  adc_rx_pkg::thr_mode_t cfg_thr_mode,
    input  adc_rx_pkg::sample_t   cfg_threshold,
    input  adc_rx_pkg::sample_t   dly_sample,
    output logic                  trig_start,
    output logic                  sync_rise
);
    import adc_rx_pkg::*;

    logic    sync_prev;
    logic    sync_wait;
    sample_t prev_dly;
    sample_t fall_diff;
    logic    start_cond;
    logic    ext_hit;
    logic    thr_hit;

    assign sync_rise = adc_sync & ~sync_prev;

    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync) begin
            sync_prev <= 1'b0;
            sync_wait <= 1'b0;
        end else begin
            sync_prev <= adc_sync;
            if (start) begin
                sync_wait <= 1'b1; // armed until the next edge
            end else if (sync_rise) begin
                sync_wait <= 1'b0;
            end
        end
    end

    // last delayed sample for the fall compare
    always_ff @(posedge ADC_ENC) begin
        prev_dly <= dly_sample;
    end

    assign fall_diff = prev_dly - dly_sample; // wraps, unsigned 14 bit

    always_comb begin
        case (cfg_thr_mode)
            THR_BELOW: thr_hit = (dly_sample < cfg_threshold);
            THR_ABOVE: thr_hit = (dly_sample > cfg_threshold);
            THR_FALL:  thr_hit = (fall_diff > cfg_threshold);
            default:   thr_hit = 1'b0;
        endcase
    end

    assign start_cond = cfg_start_with_sync ? (sync_wait & sync_rise) : start;
    assign ext_hit    = cfg_en_ext_trigger & ext_trigger;

    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync) begin
            trig_start <= 1'b0;
        end else begin
            trig_start <= start_cond | ext_hit | thr_hit;
        end
    end

endmodule
